//--- flist.f
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_mem_port.sv
src/rv_control.sv
src/rv_core.sv
tb/tb_mem_model.sv
tb/tb_rv_core.sv

//--- src/rv_alu.sv
// Combinational ALU for the core.
// Handles add/sub, logic ops and compares; shift ops move op1 by op2,
// which the control FSM keeps at 1 or 4 and repeats as needed.

`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  rv_pkg::alu_op_e alu_op,
	input  rv_pkg::word_t   op1,
	input  rv_pkg::word_t   op2,
	output rv_pkg::word_t   result
);
	import rv_pkg::*;

	logic [reg_addr_bits-1:0] shamt;

	assign shamt = op2[reg_addr_bits-1:0];

	always_comb begin
		case (alu_op)
			alu_add:
				result = op1 + op2;
			alu_sub:
				result = op1 - op2;
			alu_slt:
				result = word_t'($signed(op1) < $signed(op2));
			alu_sltu:
				result = word_t'(op1 < op2);
			alu_xor:
				result = op1 ^ op2;
			alu_or:
				result = op1 | op2;
			alu_and:
				result = op1 & op2;
			alu_sll:
				result = op1 << shamt;
			alu_srl:
				result = op1 >> shamt;
			alu_sra:
				result = word_t'($signed(op1) >>> shamt);
			// Branch compares
			alu_eq:
				result = word_t'(op1 == op2);
			alu_ne:
				result = word_t'(op1 != op2);
			alu_ge:
				result = word_t'($signed(op1) >= $signed(op2));
			alu_geu:
				result = word_t'(op1 >= op2);
			default:
				result = op1 + op2;
		endcase
	end

endmodule

`default_nettype wire

//--- src/rv_control.sv
// Main sequencer of the multi-cycle core.
// Walks fetch, decode, operand load, execute and memory states, runs
// shifts in steps of four then one, and stops in st_trap on an illegal
// instruction or a misaligned access or jump target.

`timescale 1ns/1ps
`default_nettype none

module rv_control (
	input  logic             clk,
	input  logic             resetn,
	output logic             trap,
	input  rv_pkg::decoded_t dec,
	output logic             dec_load,
	output rv_pkg::reg_idx_t raddr1,
	output rv_pkg::reg_idx_t raddr2,
	input  rv_pkg::word_t    rdata1,
	input  rv_pkg::word_t    rdata2,
	output logic             rf_we,
	output rv_pkg::reg_idx_t rf_waddr,
	output rv_pkg::word_t    rf_wdata,
	output rv_pkg::alu_op_e  alu_op,
	output rv_pkg::word_t    op1,
	output rv_pkg::word_t    op2,
	input  rv_pkg::word_t    alu_result,
	output logic             req_start,
	output rv_pkg::mem_req_t req,
	input  logic             mem_idle,
	input  logic             req_done,
	input  rv_pkg::word_t    rdata_buf
);
	import rv_pkg::*;

	cpu_state_e state;
	word_t pc;
	word_t op1_q;
	word_t op2_q;
	logic [reg_addr_bits-1:0] sh;
	logic req_pending;
	word_t pc_next4;
	word_t pc_target;
	word_t addr_eff;
	word_t jalr_target;
	logic mem_phase;
	logic misaligned;
	logic is_shift;

	assign pc_next4 = pc + 32'd4;
	assign pc_target = pc + dec.imm;
	assign addr_eff = op1_q + dec.imm;
	assign jalr_target = {alu_result[xlen-1:1], 1'b0};
	assign misaligned = (addr_eff[1:0] != 2'b00);
	assign is_shift = dec.alu_op inside {alu_sll, alu_srl, alu_sra};
	assign mem_phase = state inside {st_fetch, st_ldmem, st_stmem};

	assign trap = (state == st_trap);
	assign raddr1 = dec.rs1;
	assign raddr2 = dec.rs2;
	assign alu_op = dec.alu_op;
	assign op1 = op1_q;
	// Shift step size while iterating
	assign op2 = (state == st_shift) ? ((sh >= 5'd4) ? 32'd4 : 32'd1) : op2_q;

	// Misaligned data accesses never reach the bus
	assign req_start = mem_phase && mem_idle && !req_pending &&
		(state == st_fetch || !misaligned);
	assign dec_load = (state == st_fetch) && req_done;

	always_comb begin
		req.addr = (state == st_fetch) ? pc : addr_eff;
		req.wdata = op2_q;
		req.wstrb = (state == st_stmem) ? 4'b1111 : 4'b0000;
		req.instr = (state == st_fetch);
	end

	assign rf_waddr = dec.rd;

	always_comb begin
		rf_we = 1'b0;
		rf_wdata = op1_q;
		case (state)
			st_decode: begin
				rf_we = (dec.iclass == class_jal) && (pc_target[1:0] == 2'b00);
				rf_wdata = pc_next4;
			end
			st_exec: begin
				rf_we = (dec.iclass == class_jalr) && !jalr_target[1];
				rf_wdata = pc_next4;
			end
			st_store:
				rf_we = 1'b1;
			st_ldmem: begin
				rf_we = req_done;
				rf_wdata = rdata_buf;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_fetch;
			pc <= '0;
			req_pending <= 1'b0;
		end else begin
			if (req_start)
				req_pending <= 1'b1;
			else if (req_done)
				req_pending <= 1'b0;

			case (state)
				st_fetch: begin
					if (req_done)
						state <= st_decode;
				end
				st_decode: begin
					case (dec.iclass)
						class_illegal:
							state <= st_trap;
						class_lui, class_auipc: begin
							op1_q <= (dec.iclass == class_lui) ? '0 : pc;
							op2_q <= dec.imm;
							state <= st_exec;
						end
						class_jal: begin
							if (pc_target[1:0] != 2'b00) begin
								state <= st_trap;
							end else begin
								pc <= pc_target;
								state <= st_fetch;
							end
						end
						default:
							state <= st_ld_rs1;
					endcase
				end
				st_ld_rs1: begin
					op1_q <= rdata1;
					if (dec.iclass == class_load) begin
						state <= st_ldmem;
					end else if (dec.iclass == class_op_imm && is_shift) begin
						sh <= dec.rs2;
						state <= st_shift;
					end else if (dec.iclass == class_op_imm || dec.iclass == class_jalr) begin
						op2_q <= dec.imm;
						state <= st_exec;
					end else begin
						state <= st_ld_rs2;
					end
				end
				st_ld_rs2: begin
					op2_q <= rdata2;
					if (dec.iclass == class_store) begin
						state <= st_stmem;
					end else if (dec.iclass == class_op && is_shift) begin
						sh <= rdata2[reg_addr_bits-1:0];
						state <= st_shift;
					end else begin
						state <= st_exec;
					end
				end
				st_exec: begin
					if (dec.iclass == class_branch) begin
						if (!alu_result[0])
							pc <= pc_next4;
						else if (pc_target[1:0] == 2'b00)
							pc <= pc_target;
						state <= (alu_result[0] && pc_target[1:0] != 2'b00) ? st_trap : st_fetch;
					end else if (dec.iclass == class_jalr) begin
						if (jalr_target[1])
							state <= st_trap;
						else begin
							pc <= jalr_target;
							state <= st_fetch;
						end
					end else begin
						op1_q <= alu_result;
						state <= st_store;
					end
				end
				st_shift: begin
					if (sh == '0) begin
						state <= st_store;
					end else begin
						op1_q <= alu_result;
						sh <= (sh >= 5'd4) ? sh - 5'd4 : sh - 5'd1;
					end
				end
				st_store: begin
					pc <= pc_next4;
					state <= st_fetch;
				end
				st_ldmem, st_stmem: begin
					if (!req_pending && misaligned) begin
						state <= st_trap;
					end else if (req_done) begin
						pc <= pc_next4;
						state <= st_fetch;
					end
				end
				default: ;
			endcase
		end
	end

	pc_aligned_a: assert property (@(posedge clk) disable iff (!resetn)
		state != st_trap |-> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- src/rv_core.sv
// Top level of the multi-cycle RV32I core.
// Connects control, decoder, register file, ALU and the memory port;
// the memory port drives the native valid/ready bus.

`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  logic             clk,
	input  logic             resetn,
	output logic             trap,
	output logic             mem_valid,
	output rv_pkg::mem_req_t mem_req,
	input  logic             mem_ready,
	input  rv_pkg::word_t    mem_rdata
);
	import rv_pkg::*;

	decoded_t dec;
	logic dec_load;
	reg_idx_t raddr1, raddr2, rf_waddr;
	word_t rdata1, rdata2, rf_wdata;
	logic rf_we;
	alu_op_e alu_op;
	word_t op1, op2, alu_result;
	logic req_start, mem_idle, req_done;
	mem_req_t req;
	word_t rdata_buf;

	rv_control control_i (
		.clk(clk), .resetn(resetn), .trap(trap),
		.dec(dec), .dec_load(dec_load),
		.raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.alu_op(alu_op), .op1(op1), .op2(op2), .alu_result(alu_result),
		.req_start(req_start), .req(req), .mem_idle(mem_idle),
		.req_done(req_done), .rdata_buf(rdata_buf)
	);

	rv_decoder decoder_i (.clk(clk), .dec_load(dec_load), .instr(rdata_buf), .dec(dec));

	rv_regfile regfile_i (
		.clk(clk), .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	rv_alu alu_i (.alu_op(alu_op), .op1(op1), .op2(op2), .result(alu_result));

	rv_mem_port mem_port_i (
		.clk(clk), .resetn(resetn), .req_start(req_start), .req(req),
		.idle(mem_idle), .req_done(req_done), .rdata_buf(rdata_buf),
		.mem_valid(mem_valid), .mem_req(mem_req),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- src/rv_decoder.sv
// Instruction decoder for the RV32I subset.
// Loads a fetched word on dec_load and presents the decoded record
// on the next cycle; anything outside the subset decodes as illegal.

`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  logic             clk,
	input  logic             dec_load,
	input  rv_pkg::word_t    instr,
	output rv_pkg::decoded_t dec
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	decoded_t dec_next;

	function automatic alu_op_e funct3_op(input logic [2:0] f3);
		case (f3)
			3'b000: return alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec_next.iclass = class_illegal;
		dec_next.alu_op = alu_add;
		dec_next.rd = instr[11:7];
		dec_next.rs1 = instr[19:15];
		dec_next.rs2 = instr[24:20];
		dec_next.imm = imm_i;
		case (opcode)
			opc_lui: begin
				dec_next.iclass = class_lui;
				dec_next.imm = imm_u;
			end
			opc_auipc: begin
				dec_next.iclass = class_auipc;
				dec_next.imm = imm_u;
			end
			opc_jal: begin
				dec_next.iclass = class_jal;
				dec_next.imm = imm_j;
			end
			opc_jalr: begin
				if (funct3 == 3'b000)
					dec_next.iclass = class_jalr;
			end
			opc_branch: begin
				dec_next.iclass = class_branch;
				dec_next.imm = imm_b;
				case (funct3)
					3'b000: dec_next.alu_op = alu_eq;
					3'b001: dec_next.alu_op = alu_ne;
					3'b100: dec_next.alu_op = alu_slt;
					3'b101: dec_next.alu_op = alu_ge;
					3'b110: dec_next.alu_op = alu_sltu;
					3'b111: dec_next.alu_op = alu_geu;
					default: dec_next.iclass = class_illegal;
				endcase
			end
			opc_load: begin
				if (funct3 == 3'b010)
					dec_next.iclass = class_load;
			end
			opc_store: begin
				dec_next.imm = imm_s;
				if (funct3 == 3'b010)
					dec_next.iclass = class_store;
			end
			opc_op_imm: begin
				dec_next.iclass = class_op_imm;
				dec_next.alu_op = funct3_op(funct3);
				if (funct3 == 3'b101 && funct7 == 7'b0100000)
					dec_next.alu_op = alu_sra;
				else if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0000000)
					dec_next.iclass = class_illegal;
			end
			opc_op: begin
				dec_next.iclass = class_op;
				dec_next.alu_op = funct3_op(funct3);
				if (funct7 == 7'b0100000 && funct3 == 3'b000)
					dec_next.alu_op = alu_sub;
				else if (funct7 == 7'b0100000 && funct3 == 3'b101)
					dec_next.alu_op = alu_sra;
				else if (funct7 != 7'b0000000)
					dec_next.iclass = class_illegal;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (dec_load)
			dec <= dec_next;
	end

endmodule

`default_nettype wire

//--- src/rv_mem_port.sv
// Memory transaction unit on the native valid/ready bus.
// Takes one request per req_start, holds it on the bus until mem_ready,
// keeps the read data and pulses req_done one cycle later.

`timescale 1ns/1ps
`default_nettype none

module rv_mem_port (
	input  logic             clk,
	input  logic             resetn,
	input  logic             req_start,
	input  rv_pkg::mem_req_t req,
	output logic             idle,
	output logic             req_done,
	output rv_pkg::word_t    rdata_buf,
	output logic             mem_valid,
	output rv_pkg::mem_req_t mem_req,
	input  logic             mem_ready,
	input  rv_pkg::word_t    mem_rdata
);
	import rv_pkg::*;

	typedef enum logic {mp_idle, mp_busy} mp_state_e;

	mp_state_e state;
	mem_req_t req_q;

	assign idle = (state == mp_idle);
	assign mem_valid = (state == mp_busy);
	assign mem_req = req_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= mp_idle;
			req_done <= 1'b0;
		end else begin
			req_done <= 1'b0;
			case (state)
				mp_idle: begin
					if (req_start) begin
						req_q <= req;
						state <= mp_busy;
					end
				end
				mp_busy: begin
					if (mem_ready) begin
						if (req_q.wstrb == 4'b0000)
							rdata_buf <= mem_rdata;
						req_done <= 1'b1;
						state <= mp_idle;
					end
				end
				default: state <= mp_idle;
			endcase
		end
	end

	// Bus request must hold until accepted
	req_hold_a: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_req));

	start_when_idle_a: assert property (@(posedge clk) disable iff (!resetn)
		req_start |-> idle);

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
// Shared types and constants for the multi-cycle RV32I core.
// Every RTL block imports this package for word types, the decoded
// instruction record, ALU operation codes and the memory request format.

`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_bits = 5;

	// Major opcodes of the supported subset
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_bits-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		class_lui, class_auipc, class_jal, class_jalr, class_branch,
		class_load, class_store, class_op_imm, class_op, class_illegal
	} instr_class_e;

	// Compare ops give 0 or 1 in bit 0
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or, alu_and,
		alu_sll, alu_srl, alu_sra, alu_eq, alu_ne, alu_ge, alu_geu
	} alu_op_e;

	// Immediate shifts carry the shift amount in rs2
	typedef struct packed {
		instr_class_e iclass;
		alu_op_e      alu_op;
		reg_idx_t     rd;
		reg_idx_t     rs1;
		reg_idx_t     rs2;
		word_t        imm;
	} decoded_t;

	typedef enum logic [3:0] {
		st_fetch, st_decode, st_ld_rs1, st_ld_rs2, st_exec,
		st_shift, st_store, st_ldmem, st_stmem, st_trap
	} cpu_state_e;

	// Zero wstrb means a read
	typedef struct packed {
		word_t      addr;
		word_t      wdata;
		logic [3:0] wstrb;
		logic       instr;
	} mem_req_t;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
// General purpose register file, 32 x 32 bits.
// Two asynchronous read ports and one synchronous write port.

`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic             clk,
	input  rv_pkg::reg_idx_t raddr1,
	input  rv_pkg::reg_idx_t raddr2,
	output rv_pkg::word_t    rdata1,
	output rv_pkg::word_t    rdata2,
	input  logic             we,
	input  rv_pkg::reg_idx_t waddr,
	input  rv_pkg::word_t    wdata
);
	import rv_pkg::*;

	word_t regs [2**reg_addr_bits];

	// x0 reads as zero whatever the array holds
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clk) begin
		if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

endmodule

`default_nettype wire

//--- tb/tb_mem_model.sv
// Behavioral 4 KB word memory for the core testbench.
// Answers bus requests after a random number of wait states, drives ready
// and read data on the falling edge and reports every completed write.

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
	input  logic             clk,
	input  logic             mem_valid,
	input  rv_pkg::mem_req_t mem_req,
	output logic             mem_ready,
	output rv_pkg::word_t    mem_rdata,
	output logic             wr_log,
	output rv_pkg::word_t    wr_addr,
	output rv_pkg::word_t    wr_data
);
	import rv_pkg::*;

	// Loaded by the testbench through hierarchical access
	word_t mem [1024];
	integer seed;
	logic accept;

	initial begin
		seed = 32'he13da2f9;
		mem_ready = 1'b0;
		mem_rdata = '0;
		wr_log = 1'b0;
		wr_addr = '0;
		wr_data = '0;
	end

	// Ready about every other cycle while a request waits
	always @(negedge clk) begin
		mem_ready = 1'b0;
		if (mem_valid && ($random(seed) & 1)) begin
			mem_ready = 1'b1;
			mem_rdata = mem[mem_req.addr[11:2]];
		end
	end

	assign accept = mem_valid && mem_ready && (mem_req.wstrb != 4'b0000);

	always @(posedge clk) begin
		wr_log <= accept;
		wr_addr <= mem_req.addr;
		wr_data <= mem_req.wdata;
		if (accept)
			mem[mem_req.addr[11:2]] = mem_req.wdata;
	end

endmodule

`default_nettype wire

//--- tb/tb_rv_core.sv
// Testbench for the multi-cycle RV32I core.
// Each test encodes a short program into the memory model, resets the core
// and runs until the end marker store at 0xFFC or a trap. Every bus write
// is compared in order against values from the reference model below.

`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
	import rv_pkg::*;

	// About 600 instructions at roughly 10 cycles each, with margin
	localparam int max_cycles = 20000;
	localparam word_t data_base = 32'h100;
	localparam word_t code_base = 32'h400;
	localparam word_t end_addr = 32'hffc;
	localparam logic [6:0] lui_c = 7'b0110111;
	localparam logic [6:0] auipc_c = 7'b0010111;
	localparam logic [6:0] opimm_c = 7'b0010011;
	localparam logic [6:0] load_c = 7'b0000011;
	localparam logic [6:0] jalr_c = 7'b1100111;
	// {alt, funct3} for ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
	localparam logic [39:0] rr_ops = {4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
	localparam logic [17:0] imm_f3s = {3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
	localparam logic [17:0] br_f3s = {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	logic clk, resetn, trap, mem_valid, mem_ready, wr_log, end_seen;
	mem_req_t mem_req;
	word_t mem_rdata, wr_addr, wr_data;
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t pc_w, a, b, ap, ea, ed;
	word_t vals [4];
	logic [3:0] op;
	logic [2:0] f3;
	logic [11:0] imm12;
	logic [19:0] u20;
	logic exp_instr;
	integer seed;
	int d_off, err_cnt, err_at_start, pass_cnt, fail_cnt, cycles, n;
	string cur_name;

	rv_core dut_i (
		.clk(clk), .resetn(resetn), .trap(trap), .mem_valid(mem_valid),
		.mem_req(mem_req), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	tb_mem_model mem_i (
		.clk(clk), .mem_valid(mem_valid), .mem_req(mem_req), .mem_ready(mem_ready),
		.mem_rdata(mem_rdata), .wr_log(wr_log), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic word_t r_type(input logic [2:0] f, input logic alt,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f, rd, 7'b0110011};
	endfunction

	function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f, rd, opc};
	endfunction

	function automatic word_t s_type(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_type(input logic [2:0] f, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t u_type(input logic [6:0] opc, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic word_t j_type(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Result of an OP or OP-IMM instruction per the ISA rules
	function automatic word_t rv_ref(input logic [2:0] f, input logic alt,
			input word_t x, input word_t y);
		case (f)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'd3: return (x < y) ? 32'd1 : 32'd0;
			3'd4: return x ^ y;
			3'd5: begin
				if (alt)
					return $signed(x) >>> y[4:0];
				return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f, input word_t x, input word_t y);
		case (f)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			default: return x >= y;
		endcase
	endfunction

	task automatic emit(input word_t w);
		mem_i.mem[pc_w[11:2]] = w;
		pc_w += 4;
	endtask

	task automatic load_const(input logic [4:0] rd, input word_t v);
		word_t hi;
		// Round up the upper part when ADDI sign-extends a negative low part
		hi = v + 32'h800;
		emit(u_type(lui_c, rd, hi[31:12]));
		emit(i_type(opimm_c, 3'b000, rd, rd, v[11:0]));
	endtask

	task automatic store_expect(input logic [4:0] rs, input word_t value);
		emit(s_type(5'd31, rs, 12'(d_off)));
		exp_addr.push_back(data_base + d_off);
		exp_data.push_back(value);
		d_off += 4;
	endtask

	task automatic begin_program(input string name);
		word_t addr;
		cur_name = name;
		err_at_start = err_cnt;
		@(negedge clk);
		resetn = 1'b0;
		// Fill words carry their address and decode as illegal
		for (int i = 0; i < 1024; i++) begin
			addr = i * 4;
			mem_i.mem[i] = {~addr[15:0], addr[15:0]};
		end
		exp_addr.delete();
		exp_data.delete();
		pc_w = 0;
		emit(j_type(5'd0, 21'(code_base)));
		pc_w = code_base;
		emit(i_type(opimm_c, 3'b000, 5'd31, 5'd0, 12'(data_base)));
		d_off = 0;
	endtask

	task automatic run_program(input logic expect_trap);
		if (!expect_trap) begin
			load_const(5'd30, 32'h1000);
			emit(s_type(5'd30, 5'd0, 12'hffc));
			exp_addr.push_back(end_addr);
			exp_data.push_back('0);
			emit(j_type(5'd0, 21'd0));
		end else begin
			// Guard store, only reached if the core runs past the trap
			emit(s_type(5'd31, 5'd0, 12'h000));
		end
		end_seen = 1'b0;
		repeat (5) @(negedge clk);
		resetn = 1'b1;
		while (!end_seen && !trap)
			@(negedge clk);
		if (expect_trap) begin
			assert (trap) else begin
				$display("%s: program ended without raising trap", cur_name);
				err_cnt++;
			end
			repeat (50) begin
				@(negedge clk);
				assert (!mem_valid) else begin
					$display("%s: bus request seen after trap", cur_name);
					err_cnt++;
				end
			end
		end else begin
			assert (!trap) else begin
				$display("%s: unexpected trap", cur_name);
				err_cnt++;
			end
		end
		assert (exp_addr.size() == 0) else begin
			$display("%s: %0d expected writes never happened", cur_name, exp_addr.size());
			err_cnt++;
		end
		if (err_cnt == err_at_start) begin
			pass_cnt++;
			$display("%s: ok", cur_name);
		end else begin
			fail_cnt++;
			$display("%s: %0d errors", cur_name, err_cnt - err_at_start);
		end
	endtask

	// Checks each logged bus write against the expected list, in order
	always @(posedge clk) begin
		if (wr_log) begin
			assert (exp_addr.size() != 0) else begin
				$display("%s: write to %h when no write was expected", cur_name, wr_addr);
				err_cnt++;
			end
			if (exp_addr.size() != 0) begin
				ea = exp_addr.pop_front();
				ed = exp_data.pop_front();
				assert (wr_addr == ea) else begin
					$display("[ERROR] %s: write address expected %h actual %h",
						cur_name, ea, wr_addr);
					err_cnt++;
				end
				assert (wr_data == ed) else begin
					$display("[ERROR] %s: data at %h expected %h actual %h",
						cur_name, ea, ed, wr_data);
					err_cnt++;
				end
			end
			if (wr_addr == end_addr)
				end_seen = 1'b1;
		end
	end

	// Fetches come from the reset vector or the code area, data lies below it
	always @(posedge clk) begin
		if (mem_valid && mem_ready) begin
			exp_instr = (mem_req.wstrb == 4'b0000) &&
				(mem_req.addr == '0 || mem_req.addr >= code_base);
			assert (mem_req.instr == exp_instr) else begin
				$display("[ERROR] %s: instr flag at %h expected %b actual %b",
					cur_name, mem_req.addr, exp_instr, mem_req.instr);
				err_cnt++;
			end
			assert (mem_req.wstrb == 4'b0000 || mem_req.wstrb == 4'b1111) else begin
				$display("[ERROR] %s: write strobe at %h expected 1111 actual %b",
					cur_name, mem_req.addr, mem_req.wstrb);
				err_cnt++;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", max_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		resetn = 1'b0;
		seed = 32'he13da2f9;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		end_seen = 1'b0;

		begin_program("reg_reg_ops");
		for (int r = 0; r < 3; r++) begin
			a = $random(seed);
			b = (r == 1) ? a : $random(seed);
			load_const(5'd1, a);
			load_const(5'd2, b);
			for (int k = 0; k < 10; k++) begin
				op = rr_ops[39 - 4 * k -: 4];
				emit(r_type(op[2:0], op[3], 5'd3, 5'd1, 5'd2));
				store_expect(5'd3, rv_ref(op[2:0], op[3], a, b));
			end
		end
		run_program(1'b0);

		begin_program("imm_ops_shifts");
		a = $random(seed) | 32'h8000_0000;
		load_const(5'd1, a);
		for (int s = 0; s < 32; s++) begin
			emit(i_type(opimm_c, 3'b001, 5'd3, 5'd1, {7'b0000000, s[4:0]}));
			emit(i_type(opimm_c, 3'b101, 5'd4, 5'd1, {7'b0000000, s[4:0]}));
			emit(i_type(opimm_c, 3'b101, 5'd5, 5'd1, {7'b0100000, s[4:0]}));
			store_expect(5'd3, rv_ref(3'd1, 1'b0, a, word_t'(s)));
			store_expect(5'd4, rv_ref(3'd5, 1'b0, a, word_t'(s)));
			store_expect(5'd5, rv_ref(3'd5, 1'b1, a, word_t'(s)));
		end
		// Register shifts use only the low five bits of rs2
		for (int k = 0; k < 4; k++) begin
			b = $random(seed);
			load_const(5'd2, b);
			emit(r_type(3'd1, 1'b0, 5'd3, 5'd1, 5'd2));
			emit(r_type(3'd5, 1'b0, 5'd4, 5'd1, 5'd2));
			emit(r_type(3'd5, 1'b1, 5'd5, 5'd1, 5'd2));
			store_expect(5'd3, rv_ref(3'd1, 1'b0, a, b));
			store_expect(5'd4, rv_ref(3'd5, 1'b0, a, b));
			store_expect(5'd5, rv_ref(3'd5, 1'b1, a, b));
		end
		for (int k = 0; k < 6; k++) begin
			f3 = imm_f3s[17 - 3 * k -: 3];
			imm12 = $random(seed);
			emit(i_type(opimm_c, f3, 5'd6, 5'd1, imm12));
			store_expect(5'd6, rv_ref(f3, 1'b0, a, {{20{imm12[11]}}, imm12}));
		end
		u20 = $random(seed);
		emit(u_type(lui_c, 5'd7, u20));
		store_expect(5'd7, {u20, 12'h000});
		u20 = $random(seed);
		ap = pc_w;
		emit(u_type(auipc_c, 5'd8, u20));
		store_expect(5'd8, ap + {u20, 12'h000});
		run_program(1'b0);

		begin_program("load_store");
		for (int i = 0; i < 4; i++) begin
			vals[i] = $random(seed);
			load_const(5'd1, vals[i]);
			store_expect(5'd1, vals[i]);
		end
		// Read back through a second base register
		load_const(5'd5, data_base + 16);
		for (int i = 0; i < 4; i++) begin
			emit(i_type(load_c, 3'b010, 5'd6, 5'd5, 12'(4 * i - 16)));
			store_expect(5'd6, vals[i]);
		end
		emit(i_type(load_c, 3'b010, 5'd0, 5'd31, 12'd0));
		store_expect(5'd0, '0);
		run_program(1'b0);

		begin_program("branches_jumps");
		n = 16;
		for (int k = 0; k < 6; k++) begin
			f3 = br_f3s[17 - 3 * k -: 3];
			for (int p = 0; p < 3; p++) begin
				a = (p == 0) ? 32'hffff_ffff : (p == 1) ? 32'd1 : 32'd7;
				b = (p == 0) ? 32'd1 : (p == 1) ? 32'hffff_ffff : 32'd7;
				load_const(5'd1, a);
				load_const(5'd2, b);
				emit(b_type(f3, 5'd1, 5'd2, 13'd12));
				emit(i_type(opimm_c, 3'b000, 5'd3, 5'd0, 12'(n)));
				emit(j_type(5'd0, 21'd8));
				emit(i_type(opimm_c, 3'b000, 5'd3, 5'd0, 12'(n + 1)));
				store_expect(5'd3, branch_taken(f3, a, b) ? word_t'(n + 1) : word_t'(n));
				n += 2;
			end
		end
		ap = pc_w;
		emit(j_type(5'd5, 21'd8));
		emit(i_type(opimm_c, 3'b000, 5'd5, 5'd0, 12'h7ff));
		store_expect(5'd5, ap + 4);
		// Odd JALR offset, the target LSB is dropped
		ap = pc_w;
		load_const(5'd6, ap + 16);
		emit(i_type(jalr_c, 3'b000, 5'd7, 5'd6, 12'd1));
		emit(i_type(opimm_c, 3'b000, 5'd7, 5'd0, 12'h7ff));
		store_expect(5'd7, ap + 12);
		run_program(1'b0);

		begin_program("trap_illegal_fence");
		emit(32'h0ff0000f);
		run_program(1'b1);

		begin_program("trap_misaligned_sw");
		emit(i_type(opimm_c, 3'b000, 5'd1, 5'd0, 12'h102));
		emit(s_type(5'd1, 5'd1, 12'h000));
		run_program(1'b1);

		begin_program("trap_misaligned_jalr");
		// Target is the guard store at 0x40c plus two
		emit(i_type(opimm_c, 3'b000, 5'd1, 5'd0, 12'h40e));
		emit(i_type(jalr_c, 3'b000, 5'd2, 5'd1, 12'h000));
		run_program(1'b1);

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
